// File: sim/bus_vectors.txt
// step master we be addr wdata expected_rdata (hex, one transaction per line)
// Writes carry 0 as expected data, the last line with step ff ends the list
00 0 1 f 00010004 a0a0a0a0 00000000
00 1 1 f 00010008 b1b1b1b1 00000000
01 0 1 f 00000010 11111111 00000000
02 0 1 f 00010020 22222222 00000000
03 0 1 f 00020030 33333333 00000000
04 0 0 f 00000010 00000000 11111111
05 0 0 f 00010020 00000000 22222222
06 0 0 f 00020030 00000000 33333333
07 0 1 f 00000040 aabbccdd 00000000
08 0 1 5 00000040 11223344 00000000
09 0 0 f 00000040 00000000 aa22cc44
0a 0 0 f 00010004 00000000 a0a0a0a0
0a 1 0 f 00010008 00000000 b1b1b1b1
0b 0 0 f 00000010 00000000 11111111
0b 1 0 f 00020030 00000000 33333333
0c 0 1 f 00020050 5a5a5a5a 00000000
0d 1 0 f 00400050 00000000 5a5a5a5a
ff 0 0 0 00000000 00000000 00000000

// File: verilog.f
+incdir+hw
hw/obi_bus_pkg.sv
hw/obi_if.sv
hw/obi_addr_decode.sv
hw/obi_bank_arbiter.sv
hw/obi_sram_bank.sv
hw/system_xbar.sv
hw/mcu_bus_top.sv
sim/tb_mcu_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the OBI bus testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_mcu_bus \
  --Mdir obj_dir -o tb_mcu_bus > build.log 2>&1 \
  && ./obj_dir/tb_mcu_bus > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat build.log; exit 1; }

cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tb_mcu_bus.sv
// ------------------------------------------------
// Self-checking testbench for the OBI bus subsystem
// Replays the vector file step by step on both masters
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "obi_bus_consts.svh"

module tb_mcu_bus;

  import obi_bus_pkg::*;

  localparam int NM           = `XBAR_NMASTER;
  localparam int NFIELD       = 7;
  localparam int MAX_LINES    = 64;
  localparam int RESET_CYCLES = 16;
  localparam int STEP_CYCLES  = 40;

  logic                 clk_i;
  logic                 reset_i;
  logic      [NM-1:0]   m_req;
  logic      [NM-1:0]   m_we;
  obi_be_t   [NM-1:0]   m_be;
  obi_addr_t [NM-1:0]   m_addr;
  obi_data_t [NM-1:0]   m_wdata;
  logic      [NM-1:0]   m_gnt;
  logic      [NM-1:0]   m_rvalid;
  obi_data_t [NM-1:0]   m_rdata;

  // One field per entry, seven entries per transaction
  logic [31:0] vec [NFIELD*MAX_LINES];
  int unsigned cyc    = 0;
  int unsigned limit  = 0;
  int          errors = 0;
  int          checks = 0;

  mcu_bus_top i_mcu_bus_top (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .m_req_i    (m_req),
    .m_we_i     (m_we),
    .m_be_i     (m_be),
    .m_addr_i   (m_addr),
    .m_wdata_i  (m_wdata),
    .m_gnt_o    (m_gnt),
    .m_rvalid_o (m_rvalid),
    .m_rdata_o  (m_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  initial begin
    wait (limit != 0);
    wait (cyc >= limit);
    $display("Timeout after %0d cycles, the bus stopped answering", cyc);
    $display("ERRORS FOUND");
    $finish;
  end

  // Address map: low 1 KiB of each 64 KiB region, the rest to the default bank
  function automatic bank_idx_t bank_of(input obi_addr_t addr);
    if (addr[31:18] == '0 && addr[15:10] == '0 && addr[17:16] != 2'd3) begin
      return bank_idx_t'(addr[17:16]);
    end
    return bank_idx_t'(`DEFAULT_BANK);
  endfunction

  task automatic check_data(input string name, input obi_data_t exp, input obi_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_idle(input string name);
    for (int i = 0; i < NM; i++) begin
      check_flag($sformatf("%s gnt[%0d]", name, i), 1'b0, m_gnt[i]);
      check_flag($sformatf("%s rvalid[%0d]", name, i), 1'b0, m_rvalid[i]);
    end
  endtask

  task automatic run_step(input int s, input int first, input int n);
    logic [NM-1:0] pending;
    logic [NM-1:0] waiting;
    logic [NM-1:0] in_step;
    logic          busy;
    int unsigned   gnt_cyc [NM];
    obi_data_t     exp_rdata [NM];
    string         tag;
    int            m;
    pending = '0;
    waiting = '0;
    in_step = '0;
    @(posedge clk_i);
    #0.5;
    for (int k = first; k < first + n; k++) begin
      m            = int'(vec[k*NFIELD+1]);
      in_step[m]   = 1'b1;
      pending[m]   = 1'b1;
      m_we[m]      = vec[k*NFIELD+2][0];
      m_be[m]      = obi_be_t'(vec[k*NFIELD+3]);
      m_addr[m]    = vec[k*NFIELD+4];
      m_wdata[m]   = vec[k*NFIELD+5];
      exp_rdata[m] = vec[k*NFIELD+6];
    end
    busy = 1'b1;
    while (busy) begin
      m_req = pending;
      #1;
      for (int i = 0; i < NM; i++) begin
        tag = $sformatf("step %0d master %0d", s, i);
        if (m_rvalid[i]) begin
          check_flag({tag, " rvalid one cycle after gnt"}, 1'b1,
                     waiting[i] && (gnt_cyc[i] + 1 == cyc));
          if (!m_we[i]) begin
            check_data({tag, " rdata"}, exp_rdata[i], m_rdata[i]);
          end
          waiting[i] = 1'b0;
        end
        if (m_gnt[i] && !pending[i]) begin
          check_flag({tag, " gnt without open request"}, 1'b0, m_gnt[i]);
        end else if (m_gnt[i]) begin
          pending[i] = 1'b0;
          waiting[i] = 1'b1;
          gnt_cyc[i] = cyc;
        end
      end
      busy = (pending != '0) || (waiting != '0);
      if (busy) begin
        @(posedge clk_i);
        #0.5;
      end
    end
    // Same bank serializes, different banks run in parallel
    if (in_step == '1) begin
      tag = $sformatf("step %0d", s);
      if (bank_of(m_addr[0]) == bank_of(m_addr[1])) begin
        check_flag({tag, " grants in different cycles"}, 1'b1, gnt_cyc[0] != gnt_cyc[1]);
        if (s == 0) begin
          check_flag({tag, " master 0 granted first"}, 1'b1, gnt_cyc[0] < gnt_cyc[1]);
        end
      end else begin
        check_flag({tag, " grants in the same cycle"}, 1'b1, gnt_cyc[0] == gnt_cyc[1]);
      end
    end
  endtask

  initial begin
    int n;
    int first;
    int last;
    reset_i = 1'b1;
    m_req   = '0;
    m_we    = '0;
    m_be    = '0;
    m_addr  = '0;
    m_wdata = '0;
    $readmemh("sim/bus_vectors.txt", vec);
    n = 0;
    while (n < MAX_LINES && vec[n*NFIELD] !== 32'hff) begin
      n++;
    end
    if (n == 0 || n == MAX_LINES) begin
      errors++;
      $display("Vector file is missing, empty or lacks its end marker");
    end else begin
      limit = RESET_CYCLES + 2 + STEP_CYCLES * (int'(vec[(n-1)*NFIELD]) + 1);
    end

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk_i);
      #0.5;
      reset_i = (i < RESET_CYCLES - 1);
      #1;
      check_idle("reset");
    end
    repeat (2) begin
      @(posedge clk_i);
      #1.5;
      check_idle("after reset");
    end

    first = 0;
    while (first < n && n < MAX_LINES) begin
      last = first;
      while (last + 1 < n && vec[(last+1)*NFIELD] == vec[first*NFIELD]) begin
        last++;
      end
      run_step(int'(vec[first*NFIELD]), first, last - first + 1);
      first = last + 1;
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_mcu_bus

`default_nettype wire

// File: hw/mcu_bus_top.sv
// ------------------------------------------------
// Bus subsystem top with crossbar and SRAM banks
// Masters connect through plain per-master arrays
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "obi_bus_consts.svh"

module mcu_bus_top (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [`XBAR_NMASTER-1:0]                  m_req_i,
  input  logic [`XBAR_NMASTER-1:0]                  m_we_i,
  input  obi_bus_pkg::obi_be_t   [`XBAR_NMASTER-1:0] m_be_i,
  input  obi_bus_pkg::obi_addr_t [`XBAR_NMASTER-1:0] m_addr_i,
  input  obi_bus_pkg::obi_data_t [`XBAR_NMASTER-1:0] m_wdata_i,
  output logic [`XBAR_NMASTER-1:0]                  m_gnt_o,
  output logic [`XBAR_NMASTER-1:0]                  m_rvalid_o,
  output obi_bus_pkg::obi_data_t [`XBAR_NMASTER-1:0] m_rdata_o
);

  // Crossbar to bank links
  obi_if bank_link [`XBAR_NBANK] ();

  system_xbar #(
    .NMASTER (`XBAR_NMASTER)
  ) i_system_xbar (
    .clk_i,
    .reset_i,
    .m_req_i,
    .m_we_i,
    .m_be_i,
    .m_addr_i,
    .m_wdata_i,
    .m_gnt_o,
    .m_rvalid_o,
    .m_rdata_o,
    .bank       (bank_link)
  );

  for (genvar b = 0; b < `XBAR_NBANK; b++) begin : gen_sram
    obi_sram_bank i_sram_bank (
      .clk_i,
      .reset_i,
      .bus     (bank_link[b])
    );
  end

endmodule : mcu_bus_top

`default_nettype wire

// File: hw/system_xbar.sv
// ------------------------------------------------
// N-to-M crossbar from the masters to the SRAM banks
// Decodes, arbitrates per bank and routes responses back
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "obi_bus_consts.svh"

module system_xbar #(
  parameter  int unsigned NMASTER = 2,
  localparam int unsigned MIDX_W  = (NMASTER > 1) ? $clog2(NMASTER) : 1
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [NMASTER-1:0]                  m_req_i,
  input  logic [NMASTER-1:0]                  m_we_i,
  input  obi_bus_pkg::obi_be_t   [NMASTER-1:0] m_be_i,
  input  obi_bus_pkg::obi_addr_t [NMASTER-1:0] m_addr_i,
  input  obi_bus_pkg::obi_data_t [NMASTER-1:0] m_wdata_i,
  output logic [NMASTER-1:0]                  m_gnt_o,
  output logic [NMASTER-1:0]                  m_rvalid_o,
  output obi_bus_pkg::obi_data_t [NMASTER-1:0] m_rdata_o,
  obi_if.master                               bank [`XBAR_NBANK]
);

  import obi_bus_pkg::*;

  bank_idx_t [NMASTER-1:0]                   port_sel;
  logic      [`XBAR_NBANK-1:0][NMASTER-1:0] bank_sel;
  logic      [`XBAR_NBANK-1:0][NMASTER-1:0] bank_gnt;
  logic      [`XBAR_NBANK-1:0][MIDX_W-1:0]  choice;
  logic      [`XBAR_NBANK-1:0][MIDX_W-1:0]  owner;
  logic      [`XBAR_NBANK-1:0]              resp_valid;
  obi_data_t [`XBAR_NBANK-1:0]              bank_rdata;

  for (genvar m = 0; m < NMASTER; m++) begin : gen_decode
    obi_addr_decode i_decode (
      .addr_i (m_addr_i[m]),
      .bank_o (port_sel[m])
    );
  end

  for (genvar b = 0; b < `XBAR_NBANK; b++) begin : gen_bank
    for (genvar m = 0; m < NMASTER; m++) begin : gen_sel
      assign bank_sel[b][m] = (port_sel[m] == bank_idx_t'(b));
    end

    obi_bank_arbiter #(
      .NMASTER (NMASTER)
    ) i_arbiter (
      .clk_i,
      .reset_i,
      .req_i          (m_req_i),
      .sel_i          (bank_sel[b]),
      .gnt_o          (bank_gnt[b]),
      .slave_gnt_i    (bank[b].gnt),
      .slave_rvalid_i (bank[b].rvalid),
      .choice_o       (choice[b]),
      .resp_owner_o   (owner[b]),
      .resp_valid_o   (resp_valid[b])
    );

    // Request fields of the arbitration winner
    assign bank[b].req   = |(m_req_i & bank_sel[b]);
    assign bank[b].we    = m_we_i[choice[b]];
    assign bank[b].be    = m_be_i[choice[b]];
    assign bank[b].addr  = m_addr_i[choice[b]];
    assign bank[b].wdata = m_wdata_i[choice[b]];
    assign bank_rdata[b] = bank[b].rdata;
  end

  // A master targets one bank at a time, so OR-ing is safe
  always_comb begin
    m_gnt_o    = '0;
    m_rvalid_o = '0;
    m_rdata_o  = '0;
    for (int b = 0; b < `XBAR_NBANK; b++) begin
      m_gnt_o = m_gnt_o | bank_gnt[b];
      if (resp_valid[b]) begin
        m_rvalid_o[owner[b]] = 1'b1;
        m_rdata_o[owner[b]]  = bank_rdata[b];
      end
    end
  end

endmodule : system_xbar

`default_nettype wire

// File: hw/obi_sram_bank.sv
// ------------------------------------------------
// Word SRAM bank with byte enables on an OBI slave port
// Always grants and returns read data one cycle later
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "obi_bus_consts.svh"

module obi_sram_bank (
  input  logic clk_i,
  input  logic reset_i,
  obi_if.slave bus
);

  import obi_bus_pkg::*;

  obi_data_t  mem [`BANK_WORDS];
  bank_word_t word_idx;
  logic       rvalid_q;
  obi_data_t  rdata_q;

  // Byte address bits above the word offset
  assign word_idx = bus.addr[$bits(bank_word_t)+1:2];

  // No wait states
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      // Old word comes back on a write and the master ignores it
      rdata_q <= mem[word_idx];
      if (bus.we) begin
        for (int i = 0; i < `OBI_BEW; i++) begin
          if (bus.be[i]) begin
            mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  // A write must enable at least one byte
  a_write_has_be : assert property (@(posedge clk_i) disable iff (reset_i)
    bus.req && bus.we |-> bus.be != '0);

endmodule : obi_sram_bank

`default_nettype wire

// File: hw/obi_bank_arbiter.sv
// ------------------------------------------------
// Round-robin arbiter in front of one bank
// Grants one master per cycle and tracks who owns the response
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module obi_bank_arbiter #(
  parameter  int unsigned NMASTER = 2,
  localparam int unsigned MIDX_W  = (NMASTER > 1) ? $clog2(NMASTER) : 1
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [NMASTER-1:0] req_i,
  input  logic [NMASTER-1:0] sel_i,
  output logic [NMASTER-1:0] gnt_o,
  input  logic               slave_gnt_i,
  input  logic               slave_rvalid_i,
  output logic [MIDX_W-1:0]  choice_o,
  output logic [MIDX_W-1:0]  resp_owner_o,
  output logic               resp_valid_o
);

  logic [NMASTER-1:0] active;
  logic               found;
  logic               transfer;
  logic [MIDX_W-1:0]  rr_q;
  logic               pend_q;
  logic [MIDX_W-1:0]  owner_q;

  // Only requests aimed at this bank compete
  assign active = req_i & sel_i;

  // First active master at or after the pointer
  always_comb begin : pick
    int unsigned idx;
    found    = 1'b0;
    choice_o = rr_q;
    for (int unsigned k = 0; k < NMASTER; k++) begin
      idx = (32'(rr_q) + k) % NMASTER;
      if (!found && active[idx]) begin
        found    = 1'b1;
        choice_o = MIDX_W'(idx);
      end
    end
  end

  assign transfer = found & slave_gnt_i;

  always_comb begin
    gnt_o = '0;
    if (transfer) begin
      gnt_o[choice_o] = 1'b1;
    end
  end

  // Pointer moves past the master just served
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q   <= '0;
      pend_q <= 1'b0;
    end else begin
      pend_q <= transfer;
      if (transfer) begin
        rr_q <= (choice_o == MIDX_W'(NMASTER - 1)) ? '0 : choice_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (transfer) begin
      owner_q <= choice_o;
    end
  end

  assign resp_owner_o = owner_q;
  assign resp_valid_o = pend_q & slave_rvalid_i;

  // Grant only reaches a master that requests this bank
  a_gnt_to_active : assert property (@(posedge clk_i) disable iff (reset_i)
    (gnt_o & ~active) == '0);

  // Bank answers only for a transfer this arbiter granted
  a_rvalid_owned : assert property (@(posedge clk_i) disable iff (reset_i)
    slave_rvalid_i |-> pend_q);

endmodule : obi_bank_arbiter

`default_nettype wire

// File: hw/obi_addr_decode.sv
// ------------------------------------------------
// Address decoder for one master
// Maps a byte address onto a bank, unmapped ones go to the default
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "obi_bus_consts.svh"

module obi_addr_decode (
  input  obi_bus_pkg::obi_addr_t addr_i,
  output obi_bus_pkg::bank_idx_t bank_o
);

  import obi_bus_pkg::*;

  // Base of every bank region, in bank order
  localparam obi_addr_t BANK_BASE [`XBAR_NBANK] = '{
    `BANK0_BASE,
    `BANK1_BASE,
    `BANK2_BASE
  };

  obi_addr_t addr_region;

  assign addr_region = addr_i & `BANK_MASK;

  // Scan downwards so the lowest matching bank wins
  always_comb begin
    bank_o = bank_idx_t'(`DEFAULT_BANK);
    for (int b = `XBAR_NBANK - 1; b >= 0; b--) begin
      if (addr_region == BANK_BASE[b]) begin
        bank_o = bank_idx_t'(b);
      end
    end
  end

endmodule : obi_addr_decode

`default_nettype wire

// File: hw/obi_if.sv
// ------------------------------------------------
// One OBI link between the crossbar and a bank
// Crossbar side takes master, bank side takes slave
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface obi_if;

  import obi_bus_pkg::*;

  // Request channel, driven by the master
  logic      req;
  logic      we;
  obi_be_t   be;
  obi_addr_t addr;
  obi_data_t wdata;

  // Grant and response, driven by the slave
  logic      gnt;
  logic      rvalid;
  obi_data_t rdata;

  modport master (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface : obi_if

`default_nettype wire

// File: hw/obi_bus_pkg.sv
// ------------------------------------------------
// Shared vector types for the OBI system bus
// Import where address, data or index types are used
// ------------------------------------------------
`default_nettype none

`include "obi_bus_consts.svh"

package obi_bus_pkg;

  // Bus payload
  typedef logic [`OBI_AW-1:0]  obi_addr_t;
  typedef logic [`OBI_DW-1:0]  obi_data_t;
  typedef logic [`OBI_BEW-1:0] obi_be_t;

  // Bank selection from the decoders
  typedef logic [1:0] bank_idx_t;

  // Word address inside one SRAM bank
  typedef logic [$clog2(`BANK_WORDS)-1:0] bank_word_t;

endpackage : obi_bus_pkg

`default_nettype wire

// File: hw/obi_bus_consts.svh
// ------------------------------------------------
// Bus widths, bank geometry and the fixed address map
// Include wherever a size or a map entry is needed
// ------------------------------------------------
`ifndef OBI_BUS_CONSTS_SVH
`define OBI_BUS_CONSTS_SVH

`define OBI_AW        32
`define OBI_DW        32
`define OBI_BEW       4

`define XBAR_NMASTER  2
`define XBAR_NBANK    3
`define BANK_WORDS    256

// Each bank owns a 1 KiB window at its base
`define BANK0_BASE    32'h0000_0000
`define BANK1_BASE    32'h0001_0000
`define BANK2_BASE    32'h0002_0000
`define BANK_MASK     32'hFFFF_FC00
`define DEFAULT_BANK  2

`endif
